/* io_pkg.sv */
// shared register map, bus and pin typedefs, and the write-channel state enum for the board I/O unit
package io_pkg;

	// register bus widths
	typedef logic [7:0]  axil_addr_t;
	typedef logic [31:0] axil_data_t;
	typedef logic [1:0]  resp_t;

	// one bit per gpio pin
	typedef logic [15:0] gpio_word_t;

	// magnitude is high cycles per period, sign picks bridge side
	typedef logic signed [15:0] pwm_duty_t;
	// period in clock cycles
	typedef logic [15:0] pwm_period_t;

	// axi response codes
	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;

	// byte offsets on the register bus
	localparam axil_addr_t REG_GPIO_OUT   = 8'h00;
	localparam axil_addr_t REG_GPIO_DIR   = 8'h04;
	// read only, writes are accepted and dropped
	localparam axil_addr_t REG_GPIO_IN    = 8'h08;
	// sticky rising edges, write one to clear
	localparam axil_addr_t REG_GPIO_EDGE  = 8'h0C;
	localparam axil_addr_t REG_PWM_PERIOD = 8'h10;
	// duty registers sit at a 4 byte stride from DUTY0
	localparam axil_addr_t REG_PWM_DUTY0  = 8'h14;
	localparam axil_addr_t REG_PWM_DUTY1  = 8'h18;
	localparam axil_addr_t REG_PWM_DUTY2  = 8'h1C;
	localparam axil_addr_t REG_PWM_DUTY3  = 8'h20;

	// write channel of the register slave
	typedef enum logic
	{
		WR_IDLE,
		WR_RESP
	} wr_state_t;

endpackage

/* reset_sequencer.sv */
// holds the core reset for a fixed count after the board reset, then releases it and flags ready
`timescale 1ns/1ps

module reset_sequencer #(
	parameter int RESET_HOLD_CYCLES = 43605
) (
	input  logic clock_50mhz,
	input  logic reset2a,
	output logic core_reset_o,
	output logic core_ready_o
);

	// wide enough to hold the terminal count
	localparam int CNT_W = (RESET_HOLD_CYCLES > 1) ? $clog2(RESET_HOLD_CYCLES + 1) : 1;

	logic [CNT_W-1:0] hold_cnt;
	logic             cnt_done;

	assign cnt_done = (hold_cnt == CNT_W'(RESET_HOLD_CYCLES));

	// counter restarts on every board reset, stops at the terminal count
	always_ff @(posedge clock_50mhz)
	begin
		if (reset2a)
		begin
			hold_cnt <= '0;
		end
		else if (!cnt_done)
		begin
			hold_cnt <= hold_cnt + 1'b1;
		end
	end

	// core reset follows the count one clock late,
	// ready trails the core reset by another clock
	always_ff @(posedge clock_50mhz)
	begin
		if (reset2a)
		begin
			core_reset_o <= 1'b1;
			core_ready_o <= 1'b0;
		end
		else
		begin
			core_reset_o <= !cnt_done;
			core_ready_o <= !core_reset_o;
		end
	end

endmodule

/* axil_reg_slave.sv */
// AXI4-Lite register slave holding the GPIO and PWM control registers and serving readback
`timescale 1ns/1ps

module axil_reg_slave #(
	parameter int PWM_CHANNELS = 4
) (
	input  logic                                       clock_50mhz,
	input  logic                                       core_reset_i,
	input  logic                                       s_axil_awvalid_i,
	output logic                                       s_axil_awready_o,
	input  io_pkg::axil_addr_t                         s_axil_awaddr_i,
	input  logic                                       s_axil_wvalid_i,
	output logic                                       s_axil_wready_o,
	input  io_pkg::axil_data_t                         s_axil_wdata_i,
	input  logic [3:0]                                 s_axil_wstrb_i,
	output logic                                       s_axil_bvalid_o,
	input  logic                                       s_axil_bready_i,
	output io_pkg::resp_t                              s_axil_bresp_o,
	input  logic                                       s_axil_arvalid_i,
	output logic                                       s_axil_arready_o,
	input  io_pkg::axil_addr_t                         s_axil_araddr_i,
	output logic                                       s_axil_rvalid_o,
	input  logic                                       s_axil_rready_i,
	output io_pkg::axil_data_t                         s_axil_rdata_o,
	output io_pkg::resp_t                              s_axil_rresp_o,
	input  io_pkg::gpio_word_t                         gpio_in_i,
	input  io_pkg::gpio_word_t                         edge_flags_i,
	output io_pkg::gpio_word_t                         gpio_out_o,
	output io_pkg::gpio_word_t                         gpio_dir_o,
	output io_pkg::gpio_word_t                         edge_clear_o,
	output io_pkg::pwm_period_t                        pwm_period_o,
	output io_pkg::pwm_duty_t [PWM_CHANNELS-1:0]       pwm_duty_o
);

	import io_pkg::*;

	wr_state_t   wr_state;
	// low until the first clock out of reset, keeps every ready low in reset
	logic        bus_en_q;
	// address and data may arrive apart, each is parked until the other shows up
	logic        aw_have;
	logic        w_have;
	axil_addr_t  aw_addr_q;
	axil_data_t  w_data_q;
	logic [3:0]  w_strb_q;
	resp_t       bresp_q;
	logic        rvalid_q;
	axil_data_t  rdata_q;
	resp_t       rresp_q;

	gpio_word_t                     gpio_out_q;
	gpio_word_t                     gpio_dir_q;
	gpio_word_t                     edge_clear_q;
	pwm_period_t                    pwm_period_q;
	pwm_duty_t [PWM_CHANNELS-1:0]   pwm_duty_q;

	logic        aw_hs;
	logic        w_hs;
	logic        ar_hs;
	logic        wr_go;
	axil_addr_t  wr_addr;
	axil_data_t  wr_data;
	logic [3:0]  wr_strb;
	axil_data_t  wr_merged;
	axil_data_t  wr_mask;

	// byte offset of a duty register
	function automatic axil_addr_t duty_addr(input int ch);
		return axil_addr_t'(REG_PWM_DUTY0 + 4 * ch);
	endfunction

	// true for every offset in the register map
	function automatic logic is_mapped(input axil_addr_t addr);
		logic hit;
		hit = (addr == REG_GPIO_OUT) || (addr == REG_GPIO_DIR) || (addr == REG_GPIO_IN) ||
			(addr == REG_GPIO_EDGE) || (addr == REG_PWM_PERIOD);
		for (int i = 0; i < PWM_CHANNELS; i++)
		begin
			if (addr == duty_addr(i))
				hit = 1'b1;
		end
		return hit;
	endfunction

	// current register contents, zero for holes in the map
	function automatic axil_data_t reg_value(input axil_addr_t addr);
		axil_data_t val;
		case (addr)
			REG_GPIO_OUT:   val = {16'h0, gpio_out_q};
			REG_GPIO_DIR:   val = {16'h0, gpio_dir_q};
			REG_GPIO_IN:    val = {16'h0, gpio_in_i};
			REG_GPIO_EDGE:  val = {16'h0, edge_flags_i};
			REG_PWM_PERIOD: val = {16'h0, pwm_period_q};
			default:        val = '0;
		endcase
		for (int i = 0; i < PWM_CHANNELS; i++)
		begin
			if (addr == duty_addr(i))
				val = {16'h0, pwm_duty_q[i]};
		end
		return val;
	endfunction

	// strobed bytes come from the new word, the rest from the old
	function automatic axil_data_t apply_strb(input axil_data_t old_v,
		input axil_data_t new_v, input logic [3:0] strb);
		axil_data_t res;
		res = old_v;
		for (int b = 0; b < 4; b++)
		begin
			if (strb[b])
				res[8*b +: 8] = new_v[8*b +: 8];
		end
		return res;
	endfunction

	assign s_axil_awready_o = bus_en_q && (wr_state == WR_IDLE) && !aw_have;
	assign s_axil_wready_o  = bus_en_q && (wr_state == WR_IDLE) && !w_have;
	assign s_axil_bvalid_o  = (wr_state == WR_RESP);
	assign s_axil_bresp_o   = bresp_q;
	// one read in flight, no new address until rdata is taken
	assign s_axil_arready_o = bus_en_q && !rvalid_q;
	assign s_axil_rvalid_o  = rvalid_q;
	assign s_axil_rdata_o   = rdata_q;
	assign s_axil_rresp_o   = rresp_q;

	assign aw_hs = s_axil_awvalid_i && s_axil_awready_o;
	assign w_hs  = s_axil_wvalid_i && s_axil_wready_o;
	assign ar_hs = s_axil_arvalid_i && s_axil_arready_o;

	// parked value if already taken, else the live bus
	assign wr_addr = aw_have ? aw_addr_q : s_axil_awaddr_i;
	assign wr_data = w_have ? w_data_q : s_axil_wdata_i;
	assign wr_strb = w_have ? w_strb_q : s_axil_wstrb_i;
	assign wr_go   = (wr_state == WR_IDLE) && (aw_have || aw_hs) && (w_have || w_hs);

	assign wr_merged = apply_strb(reg_value(wr_addr), wr_data, wr_strb);
	// edge clear uses only the written ones, not the flags already set
	assign wr_mask   = apply_strb('0, wr_data, wr_strb);

	// write channel fsm and register storage
	always_ff @(posedge clock_50mhz)
	begin
		if (core_reset_i)
		begin
			wr_state     <= WR_IDLE;
			bus_en_q     <= 1'b0;
			aw_have      <= 1'b0;
			w_have       <= 1'b0;
			gpio_out_q   <= '0;
			gpio_dir_q   <= '0;
			edge_clear_q <= '0;
			pwm_period_q <= '0;
			pwm_duty_q   <= '0;
		end
		else
		begin
			bus_en_q     <= 1'b1;
			// clear mask is a single-cycle pulse
			edge_clear_q <= '0;
			case (wr_state)
				WR_IDLE:
				begin
					if (wr_go)
					begin
						wr_state <= WR_RESP;
						aw_have  <= 1'b0;
						w_have   <= 1'b0;
						case (wr_addr)
							REG_GPIO_OUT:   gpio_out_q   <= wr_merged[15:0];
							REG_GPIO_DIR:   gpio_dir_q   <= wr_merged[15:0];
							REG_GPIO_EDGE:  edge_clear_q <= wr_mask[15:0];
							REG_PWM_PERIOD: pwm_period_q <= wr_merged[15:0];
							default:        ;
						endcase
						for (int i = 0; i < PWM_CHANNELS; i++)
						begin
							if (wr_addr == duty_addr(i))
								pwm_duty_q[i] <= wr_merged[15:0];
						end
					end
					else
					begin
						if (aw_hs)
							aw_have <= 1'b1;
						if (w_hs)
							w_have <= 1'b1;
					end
				end
				WR_RESP:
				begin
					// held until the master takes it
					if (s_axil_bready_i)
						wr_state <= WR_IDLE;
				end
				default: wr_state <= WR_IDLE;
			endcase
		end
	end

	// read channel valid
	always_ff @(posedge clock_50mhz)
	begin
		if (core_reset_i)
			rvalid_q <= 1'b0;
		else if (ar_hs)
			rvalid_q <= 1'b1;
		else if (s_axil_rready_i)
			rvalid_q <= 1'b0;
	end

	// parked bus payload and response words
	always_ff @(posedge clock_50mhz)
	begin
		if (aw_hs)
			aw_addr_q <= s_axil_awaddr_i;
		if (w_hs)
		begin
			w_data_q <= s_axil_wdata_i;
			w_strb_q <= s_axil_wstrb_i;
		end
		if (wr_go)
			bresp_q <= is_mapped(wr_addr) ? RESP_OKAY : RESP_SLVERR;
		// read data registered at the address handshake
		if (ar_hs)
		begin
			rdata_q <= reg_value(s_axil_araddr_i);
			rresp_q <= is_mapped(s_axil_araddr_i) ? RESP_OKAY : RESP_SLVERR;
		end
	end

	assign gpio_out_o   = gpio_out_q;
	assign gpio_dir_o   = gpio_dir_q;
	assign edge_clear_o = edge_clear_q;
	assign pwm_period_o = pwm_period_q;
	assign pwm_duty_o   = pwm_duty_q;

endmodule

/* gpio_port.sv */
// GPIO pin stage: direction-masked outputs, input synchronizer and sticky rising-edge flags
`timescale 1ns/1ps

module gpio_port (
	input  logic               clock_50mhz,
	input  logic               core_reset_i,
	input  io_pkg::gpio_word_t gpio_out_i,
	input  io_pkg::gpio_word_t gpio_dir_i,
	input  io_pkg::gpio_word_t edge_clear_i,
	input  io_pkg::gpio_word_t gpio_pins_i,
	output io_pkg::gpio_word_t gpio_out_o,
	output io_pkg::gpio_word_t gpio_oe_o,
	output io_pkg::gpio_word_t gpio_in_o,
	output io_pkg::gpio_word_t edge_flags_o
);

	import io_pkg::*;

	// two flops for metastability, third one holds last value for edge detect
	gpio_word_t pin_meta;
	gpio_word_t pin_sync;
	gpio_word_t pin_last;
	gpio_word_t pin_rise;
	gpio_word_t edge_q;

	// pad ring takes value and enable separately
	// undriven pins show 0 on the value side
	assign gpio_oe_o  = gpio_dir_i;
	assign gpio_out_o = gpio_out_i & gpio_dir_i;

	// synchronizer keeps sampling in reset,
	// so pins already high at release give no false edge
	always_ff @(posedge clock_50mhz)
	begin
		pin_meta <= gpio_pins_i;
		pin_sync <= pin_meta;
		pin_last <= pin_sync;
	end

	assign pin_rise = pin_sync & ~pin_last;

	// sticky flags, a new edge beats a clear in the same cycle
	always_ff @(posedge clock_50mhz)
	begin
		if (core_reset_i)
			edge_q <= '0;
		else
			edge_q <= (edge_q & ~edge_clear_i) | pin_rise;
	end

	assign gpio_in_o    = pin_sync;
	assign edge_flags_o = edge_q;

endmodule

/* hbridge_pwm.sv */
// H-bridge PWM driver: signed duty per channel drives either the forward or the reverse pin
`timescale 1ns/1ps

module hbridge_pwm #(
	parameter int PWM_CHANNELS = 4
) (
	input  logic                                  clock_50mhz,
	input  logic                                  core_reset_i,
	input  io_pkg::pwm_period_t                   pwm_period_i,
	input  io_pkg::pwm_duty_t [PWM_CHANNELS-1:0]  pwm_duty_i,
	output logic [2*PWM_CHANNELS-1:0]             hbr_pins_o
);

	import io_pkg::*;

	pwm_period_t                   cnt_q;
	// shadow copies, only reloaded at the wrap
	pwm_period_t                   period_sh;
	pwm_duty_t [PWM_CHANNELS-1:0]  duty_sh;
	logic                          cnt_wrap;
	logic [2*PWM_CHANNELS-1:0]     pin_next;
	logic [2*PWM_CHANNELS-1:0]     pins_q;

	// 17 bits so a zero period wraps every cycle instead of underflowing
	assign cnt_wrap = ({1'b0, cnt_q} + 17'd1) >= {1'b0, period_sh};

	always_ff @(posedge clock_50mhz)
	begin
		if (core_reset_i)
		begin
			cnt_q     <= '0;
			period_sh <= '0;
			duty_sh   <= '0;
		end
		else if (cnt_wrap)
		begin
			cnt_q     <= '0;
			period_sh <= pwm_period_i;
			duty_sh   <= pwm_duty_i;
		end
		else
		begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	for (genvar i = 0; i < PWM_CHANNELS; i++)
	begin : g_chan
		logic        neg;
		logic [16:0] mag;
		logic [16:0] lim;
		logic        high;

		assign neg  = duty_sh[i][15];
		// abs value, -32768 still fits in 17 bits
		assign mag  = neg ? ({1'b0, ~duty_sh[i]} + 17'd1) : {1'b0, duty_sh[i]};
		// duty larger than the period means always on
		assign lim  = (mag > {1'b0, period_sh}) ? {1'b0, period_sh} : mag;
		assign high = ({1'b0, cnt_q} < lim);

		// only the sign side ever drives, the other leg stays low
		assign pin_next[2*i]   = high && !neg;
		assign pin_next[2*i+1] = high && neg;
	end

	// pins lag the counter by one clock
	always_ff @(posedge clock_50mhz)
	begin
		if (core_reset_i)
			pins_q <= '0;
		else
			pins_q <= pin_next;
	end

	assign hbr_pins_o = pins_q;

endmodule

/* board_io_top.sv */
// board I/O unit top: reset sequencer, AXI4-Lite register slave, GPIO port and H-bridge PWM
`timescale 1ns/1ps

module board_io_top #(
	parameter int RESET_HOLD_CYCLES = 43605,
	parameter int PWM_CHANNELS      = 4
) (
	input  logic                      clock_50mhz,
	input  logic                      reset2a,
	input  logic                      s_axil_awvalid_i,
	output logic                      s_axil_awready_o,
	input  io_pkg::axil_addr_t        s_axil_awaddr_i,
	input  logic                      s_axil_wvalid_i,
	output logic                      s_axil_wready_o,
	input  io_pkg::axil_data_t        s_axil_wdata_i,
	input  logic [3:0]                s_axil_wstrb_i,
	output logic                      s_axil_bvalid_o,
	input  logic                      s_axil_bready_i,
	output io_pkg::resp_t             s_axil_bresp_o,
	input  logic                      s_axil_arvalid_i,
	output logic                      s_axil_arready_o,
	input  io_pkg::axil_addr_t        s_axil_araddr_i,
	output logic                      s_axil_rvalid_o,
	input  logic                      s_axil_rready_i,
	output io_pkg::axil_data_t        s_axil_rdata_o,
	output io_pkg::resp_t             s_axil_rresp_o,
	input  io_pkg::gpio_word_t        gpio_pins_i,
	output io_pkg::gpio_word_t        gpio_out_o,
	output io_pkg::gpio_word_t        gpio_oe_o,
	output logic [2*PWM_CHANNELS-1:0] hbr_pins_o,
	output logic                      core_ready_o
);

	import io_pkg::*;

	// shared synchronous reset for everything past the sequencer
	logic                          core_reset;
	gpio_word_t                    gpio_out_reg;
	gpio_word_t                    gpio_dir_reg;
	gpio_word_t                    edge_clear;
	gpio_word_t                    gpio_in_sync;
	gpio_word_t                    edge_flags;
	pwm_period_t                   pwm_period;
	pwm_duty_t [PWM_CHANNELS-1:0]  pwm_duty;

	reset_sequencer #(
		.RESET_HOLD_CYCLES (RESET_HOLD_CYCLES)
	) i_reset_seq (
		.clock_50mhz  (clock_50mhz),
		.reset2a      (reset2a),
		.core_reset_o (core_reset),
		.core_ready_o (core_ready_o)
	);

	axil_reg_slave #(
		.PWM_CHANNELS (PWM_CHANNELS)
	) i_regs (
		.clock_50mhz      (clock_50mhz),
		.core_reset_i     (core_reset),
		.s_axil_awvalid_i (s_axil_awvalid_i),
		.s_axil_awready_o (s_axil_awready_o),
		.s_axil_awaddr_i  (s_axil_awaddr_i),
		.s_axil_wvalid_i  (s_axil_wvalid_i),
		.s_axil_wready_o  (s_axil_wready_o),
		.s_axil_wdata_i   (s_axil_wdata_i),
		.s_axil_wstrb_i   (s_axil_wstrb_i),
		.s_axil_bvalid_o  (s_axil_bvalid_o),
		.s_axil_bready_i  (s_axil_bready_i),
		.s_axil_bresp_o   (s_axil_bresp_o),
		.s_axil_arvalid_i (s_axil_arvalid_i),
		.s_axil_arready_o (s_axil_arready_o),
		.s_axil_araddr_i  (s_axil_araddr_i),
		.s_axil_rvalid_o  (s_axil_rvalid_o),
		.s_axil_rready_i  (s_axil_rready_i),
		.s_axil_rdata_o   (s_axil_rdata_o),
		.s_axil_rresp_o   (s_axil_rresp_o),
		.gpio_in_i        (gpio_in_sync),
		.edge_flags_i     (edge_flags),
		.gpio_out_o       (gpio_out_reg),
		.gpio_dir_o       (gpio_dir_reg),
		.edge_clear_o     (edge_clear),
		.pwm_period_o     (pwm_period),
		.pwm_duty_o       (pwm_duty)
	);

	gpio_port i_gpio (
		.clock_50mhz  (clock_50mhz),
		.core_reset_i (core_reset),
		.gpio_out_i   (gpio_out_reg),
		.gpio_dir_i   (gpio_dir_reg),
		.edge_clear_i (edge_clear),
		.gpio_pins_i  (gpio_pins_i),
		.gpio_out_o   (gpio_out_o),
		.gpio_oe_o    (gpio_oe_o),
		.gpio_in_o    (gpio_in_sync),
		.edge_flags_o (edge_flags)
	);

	hbridge_pwm #(
		.PWM_CHANNELS (PWM_CHANNELS)
	) i_pwm (
		.clock_50mhz  (clock_50mhz),
		.core_reset_i (core_reset),
		.pwm_period_i (pwm_period),
		.pwm_duty_i   (pwm_duty),
		.hbr_pins_o   (hbr_pins_o)
	);

endmodule

/* tb_clock_gen.sv */
// testbench clock and board reset source, 20 ns clock with reset held for the first cycles
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int RESET_CYCLES = 4
) (
	output logic clock_50mhz_o,
	output logic reset2a_o
);

	// 50 MHz, 10 ns per half period
	initial
	begin
		clock_50mhz_o = 1'b0;
		forever #10 clock_50mhz_o = ~clock_50mhz_o;
	end

	// release on a falling edge, away from the sampling edge
	initial
	begin
		reset2a_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock_50mhz_o);
		@(negedge clock_50mhz_o);
		reset2a_o = 1'b0;
	end

endmodule

/* board_io_props.sv */
// AXI4-Lite handshake and H-bridge pin assertions, bound into the board I/O top level
`timescale 1ns/1ps

module board_io_props #(
	parameter int PWM_CHANNELS = 4
) (
	input logic                      clock_50mhz,
	input logic                      core_reset_i,
	input logic                      awvalid_i,
	input logic                      awready_i,
	input logic                      wvalid_i,
	input logic                      wready_i,
	input logic                      bvalid_i,
	input logic                      bready_i,
	input logic [1:0]                bresp_i,
	input logic                      arvalid_i,
	input logic                      arready_i,
	input logic                      rvalid_i,
	input logic                      rready_i,
	input logic [31:0]               rdata_i,
	input logic [1:0]                rresp_i,
	input logic [2*PWM_CHANNELS-1:0] hbr_pins_i
);

	// write address taken, response not yet returned
	logic aw_open;

	always_ff @(posedge clock_50mhz)
	begin
		if (core_reset_i)
			aw_open <= 1'b0;
		else if (awvalid_i && awready_i)
			aw_open <= 1'b1;
		else if (bvalid_i && bready_i)
			aw_open <= 1'b0;
	end

	// master side valids hold until accepted
	a_aw_hold: assert property (@(posedge clock_50mhz) disable iff (core_reset_i)
		awvalid_i && !awready_i |=> awvalid_i) else $error("awvalid dropped before handshake");
	a_w_hold: assert property (@(posedge clock_50mhz) disable iff (core_reset_i)
		wvalid_i && !wready_i |=> wvalid_i) else $error("wvalid dropped before handshake");
	a_ar_hold: assert property (@(posedge clock_50mhz) disable iff (core_reset_i)
		arvalid_i && !arready_i |=> arvalid_i) else $error("arvalid dropped before handshake");

	// slave responses hold with a stable payload under back-pressure
	a_b_hold: assert property (@(posedge clock_50mhz) disable iff (core_reset_i)
		bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
		else $error("write response changed before bready");
	a_r_hold: assert property (@(posedge clock_50mhz) disable iff (core_reset_i)
		rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rresp_i))
		else $error("read response changed before rready");

	// responses only follow an address handshake
	a_b_cause: assert property (@(posedge clock_50mhz) disable iff (core_reset_i)
		$rose(bvalid_i) |-> aw_open) else $error("bvalid without a write address");
	a_r_cause: assert property (@(posedge clock_50mhz) disable iff (core_reset_i)
		$rose(rvalid_i) |-> $past(arvalid_i && arready_i))
		else $error("rvalid without a read address");

	// forward and reverse legs of one bridge never on together
	for (genvar i = 0; i < PWM_CHANNELS; i++)
	begin : g_pair
		a_pair: assert property (@(posedge clock_50mhz) disable iff (core_reset_i)
			!(hbr_pins_i[2*i] && hbr_pins_i[2*i+1])) else $error("bridge %0d shoot-through", i);
	end

endmodule

bind board_io_top board_io_props #(
	.PWM_CHANNELS (PWM_CHANNELS)
) i_props (
	.clock_50mhz  (clock_50mhz),
	.core_reset_i (core_reset),
	.awvalid_i    (s_axil_awvalid_i),
	.awready_i    (s_axil_awready_o),
	.wvalid_i     (s_axil_wvalid_i),
	.wready_i     (s_axil_wready_o),
	.bvalid_i     (s_axil_bvalid_o),
	.bready_i     (s_axil_bready_i),
	.bresp_i      (s_axil_bresp_o),
	.arvalid_i    (s_axil_arvalid_i),
	.arready_i    (s_axil_arready_o),
	.rvalid_i     (s_axil_rvalid_o),
	.rready_i     (s_axil_rready_i),
	.rdata_i      (s_axil_rdata_o),
	.rresp_i      (s_axil_rresp_o),
	.hbr_pins_i   (hbr_pins_o)
);

/* board_io_tb.sv */
// testbench for the board I/O unit, runs reset timing, a register table, GPIO and PWM checks
`timescale 1ns/1ps

module board_io_tb;

	import io_pkg::*;

	localparam int HOLD    = 64;
	localparam int TIMEOUT = 200;
	// longest PWM period left over from the register table
	localparam int PWM_TIMEOUT = 10000;

	logic        clock_50mhz;
	logic        reset2a;
	logic        awvalid;
	logic        awready;
	axil_addr_t  awaddr;
	logic        wvalid;
	logic        wready;
	axil_data_t  wdata;
	logic [3:0]  wstrb;
	logic        bvalid;
	logic        bready;
	resp_t       bresp;
	logic        arvalid;
	logic        arready;
	axil_addr_t  araddr;
	logic        rvalid;
	logic        rready;
	axil_data_t  rdata;
	resp_t       rresp;
	gpio_word_t  gpio_pins;
	gpio_word_t  gpio_out;
	gpio_word_t  gpio_oe;
	logic [7:0]  hbr_pins;
	logic        core_ready;

	int errors;
	int checks;

	// stimulus table, one entry per bus access
	string      tab_name[$];
	bit         tab_write[$];
	axil_addr_t tab_addr[$];
	axil_data_t tab_data[$];
	logic [3:0] tab_strb[$];
	resp_t      tab_resp[$];
	axil_data_t tab_rdata[$];

	tb_clock_gen i_clk (
		.clock_50mhz_o (clock_50mhz),
		.reset2a_o     (reset2a)
	);

	board_io_top #(
		.RESET_HOLD_CYCLES (HOLD)
	) i_dut (
		.clock_50mhz      (clock_50mhz),
		.reset2a          (reset2a),
		.s_axil_awvalid_i (awvalid),
		.s_axil_awready_o (awready),
		.s_axil_awaddr_i  (awaddr),
		.s_axil_wvalid_i  (wvalid),
		.s_axil_wready_o  (wready),
		.s_axil_wdata_i   (wdata),
		.s_axil_wstrb_i   (wstrb),
		.s_axil_bvalid_o  (bvalid),
		.s_axil_bready_i  (bready),
		.s_axil_bresp_o   (bresp),
		.s_axil_arvalid_i (arvalid),
		.s_axil_arready_o (arready),
		.s_axil_araddr_i  (araddr),
		.s_axil_rvalid_o  (rvalid),
		.s_axil_rready_i  (rready),
		.s_axil_rdata_o   (rdata),
		.s_axil_rresp_o   (rresp),
		.gpio_pins_i      (gpio_pins),
		.gpio_out_o       (gpio_out),
		.gpio_oe_o        (gpio_oe),
		.hbr_pins_o       (hbr_pins),
		.core_ready_o     (core_ready)
	);

	task automatic check_equal(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("Mismatch %s: expected 0x%08h actual 0x%08h", name, expected, actual);
		end
	endtask

	task automatic report_timeout(input string what);
		errors++;
		$display("Error: timed out waiting for %s", what);
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clock_50mhz);
	endtask

	task automatic add_row(input string name, input bit wr, input axil_addr_t addr,
		input axil_data_t data, input logic [3:0] strb, input resp_t resp, input axil_data_t rd);
		tab_name.push_back(name);
		tab_write.push_back(wr);
		tab_addr.push_back(addr);
		tab_data.push_back(data);
		tab_strb.push_back(strb);
		tab_resp.push_back(resp);
		tab_rdata.push_back(rd);
	endtask

	// entered and left on a falling edge, stall holds bready low after bvalid
	task automatic write_reg(input string name, input axil_addr_t addr, input axil_data_t data,
		input logic [3:0] strb, input int stall, output resp_t resp);
		int   t;
		logic aw_fire;
		logic w_fire;
		resp    = 'x;
		awaddr  = addr;
		wdata   = data;
		wstrb   = strb;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		t       = 0;
		while ((awvalid || wvalid) && t < TIMEOUT)
		begin
			// ready at the falling edge, so the transfer lands on the next rise
			aw_fire = awvalid && awready;
			w_fire  = wvalid && wready;
			@(negedge clock_50mhz);
			if (aw_fire)
				awvalid = 1'b0;
			if (w_fire)
				wvalid = 1'b0;
			t++;
		end
		if (awvalid || wvalid)
		begin
			awvalid = 1'b0;
			wvalid  = 1'b0;
			report_timeout({"write handshake of ", name});
			return;
		end
		t = 0;
		while (!bvalid && t < TIMEOUT)
		begin
			@(negedge clock_50mhz);
			t++;
		end
		if (!bvalid)
		begin
			report_timeout({"write response of ", name});
			return;
		end
		resp = bresp;
		for (int i = 0; i < stall; i++)
		begin
			@(negedge clock_50mhz);
			check_equal({name, " bvalid held"}, 32'd1, bvalid);
			check_equal({name, " bresp held"}, resp, bresp);
			// no new write address while the response waits
			check_equal({name, " awready stalled"}, 32'd0, awready);
		end
		bready = 1'b1;
		@(negedge clock_50mhz);
		bready = 1'b0;
	endtask

	task automatic read_reg(input string name, input axil_addr_t addr, input int stall,
		output axil_data_t data, output resp_t resp);
		int   t;
		logic ar_fire;
		data    = 'x;
		resp    = 'x;
		araddr  = addr;
		arvalid = 1'b1;
		t       = 0;
		while (arvalid && t < TIMEOUT)
		begin
			ar_fire = arready;
			@(negedge clock_50mhz);
			if (ar_fire)
				arvalid = 1'b0;
			t++;
		end
		if (arvalid)
		begin
			arvalid = 1'b0;
			report_timeout({"read address of ", name});
			return;
		end
		t = 0;
		while (!rvalid && t < TIMEOUT)
		begin
			@(negedge clock_50mhz);
			t++;
		end
		if (!rvalid)
		begin
			report_timeout({"read data of ", name});
			return;
		end
		data = rdata;
		resp = rresp;
		for (int i = 0; i < stall; i++)
		begin
			@(negedge clock_50mhz);
			check_equal({name, " rvalid held"}, 32'd1, rvalid);
			check_equal({name, " rdata held"}, data, rdata);
			check_equal({name, " rresp held"}, resp, rresp);
			check_equal({name, " arready stalled"}, 32'd0, arready);
		end
		rready = 1'b1;
		@(negedge clock_50mhz);
		rready = 1'b0;
	endtask

	// outputs quiet during the hold, then ready after the hold plus two registers
	task automatic measure_reset();
		int t;
		int n;
		t = 0;
		do
		begin
			@(posedge clock_50mhz);
			t++;
		end
		while (reset2a !== 1'b0 && t < TIMEOUT);
		if (reset2a !== 1'b0)
		begin
			report_timeout("reset2a release");
			return;
		end
		n = 1;
		@(negedge clock_50mhz);
		while (core_ready !== 1'b1 && n < HOLD + 20)
		begin
			check_equal("ready/valid in reset", 32'd0, {awready, wready, arready, bvalid, rvalid});
			check_equal("gpio_oe in reset", 32'd0, gpio_oe);
			check_equal("gpio_out in reset", 32'd0, gpio_out);
			check_equal("hbr_pins in reset", 32'd0, hbr_pins);
			@(posedge clock_50mhz);
			n++;
			@(negedge clock_50mhz);
		end
		if (core_ready !== 1'b1)
			report_timeout("core_ready_o after reset");
		else
			check_equal("core_ready delay", HOLD + 2, n);
	endtask

	// high cycles per period for one pin, from the signed duty rule
	function automatic int expected_highs(input int pin, input int duty, input int period);
		int mag;
		mag = (duty < 0) ? -duty : duty;
		if ((duty < 0) != (pin % 2 == 1))
			return 0;
		return (mag > period) ? period : mag;
	endfunction

	initial
	begin
		resp_t      got_resp;
		axil_data_t got_data;
		gpio_word_t pat;
		gpio_word_t pat_a;
		gpio_word_t pat_b;
		gpio_word_t clr;
		int         t;
		logic       prev;
		int         highs[8];
		int         duty_set[4];

		void'($urandom(50463));
		errors  = 0;
		checks  = 0;
		awvalid = 1'b0;
		awaddr  = '0;
		wvalid  = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		bready  = 1'b0;
		arvalid = 1'b0;
		araddr  = '0;
		rready  = 1'b0;
		gpio_pins = '0;

		measure_reset();

		// name, write, offset, data, strobes, response, read data
		add_row("out full", 1, REG_GPIO_OUT, 32'h0000A5C3, 4'hF, RESP_OKAY, 0);
		add_row("out full rd", 0, REG_GPIO_OUT, 0, 0, RESP_OKAY, 32'h0000A5C3);
		add_row("out byte1", 1, REG_GPIO_OUT, 32'h00001200, 4'b0010, RESP_OKAY, 0);
		add_row("out byte1 rd", 0, REG_GPIO_OUT, 0, 0, RESP_OKAY, 32'h000012C3);
		add_row("dir full", 1, REG_GPIO_DIR, 32'h0000FF0F, 4'hF, RESP_OKAY, 0);
		add_row("dir byte0", 1, REG_GPIO_DIR, 32'hABCD0033, 4'b0001, RESP_OKAY, 0);
		add_row("dir rd", 0, REG_GPIO_DIR, 0, 0, RESP_OKAY, 32'h0000FF33);
		add_row("period full", 1, REG_PWM_PERIOD, 32'h00001234, 4'hF, RESP_OKAY, 0);
		// upper lanes land outside the 16-bit register
		add_row("period hi", 1, REG_PWM_PERIOD, 32'h56780000, 4'b1100, RESP_OKAY, 0);
		add_row("period rd", 0, REG_PWM_PERIOD, 0, 0, RESP_OKAY, 32'h00001234);
		add_row("duty0", 1, REG_PWM_DUTY0, 32'hFFFF8001, 4'hF, RESP_OKAY, 0);
		add_row("duty0 rd", 0, REG_PWM_DUTY0, 0, 0, RESP_OKAY, 32'h00008001);
		add_row("duty3", 1, REG_PWM_DUTY3, 32'h00000777, 4'hF, RESP_OKAY, 0);
		add_row("duty3 byte1", 1, REG_PWM_DUTY3, 32'h00004400, 4'b0010, RESP_OKAY, 0);
		add_row("duty3 rd", 0, REG_PWM_DUTY3, 0, 0, RESP_OKAY, 32'h00004477);
		add_row("gpio_in wr", 1, REG_GPIO_IN, 32'h0000FFFF, 4'hF, RESP_OKAY, 0);
		add_row("gpio_in rd", 0, REG_GPIO_IN, 0, 0, RESP_OKAY, 32'h00000000);
		add_row("hole wr", 1, 8'h24, 32'h12345678, 4'hF, RESP_SLVERR, 0);
		add_row("hole rd", 0, 8'h24, 0, 0, RESP_SLVERR, 32'h00000000);
		add_row("odd rd", 0, 8'h03, 0, 0, RESP_SLVERR, 32'h00000000);

		for (int i = 0; i < tab_name.size(); i++)
		begin
			if (tab_write[i])
			begin
				write_reg(tab_name[i], tab_addr[i], tab_data[i], tab_strb[i], 0, got_resp);
				check_equal({tab_name[i], " bresp"}, tab_resp[i], got_resp);
			end
			else
			begin
				read_reg(tab_name[i], tab_addr[i], 0, got_data, got_resp);
				check_equal({tab_name[i], " rresp"}, tab_resp[i], got_resp);
				check_equal({tab_name[i], " rdata"}, tab_rdata[i], got_data);
			end
		end

		// pin outputs follow direction
		write_reg("out pins", REG_GPIO_OUT, 32'h00005A5A, 4'hF, 0, got_resp);
		write_reg("dir pins", REG_GPIO_DIR, 32'h00000FF0, 4'hF, 0, got_resp);
		check_equal("gpio_oe", 32'h00000FF0, gpio_oe);
		check_equal("gpio_out", 32'h00000A50, gpio_out);

		// random pin levels through the synchronizer
		for (int k = 0; k < 4; k++)
		begin
			pat       = 16'($urandom());
			gpio_pins = pat;
			wait_cycles(3);
			read_reg("gpio_in random", REG_GPIO_IN, 0, got_data, got_resp);
			check_equal("gpio_in random", {16'h0, pat}, got_data);
		end

		// sticky edges from a known starting level
		pat_a     = 16'($urandom());
		pat_b     = 16'($urandom());
		clr       = 16'($urandom());
		gpio_pins = pat_a;
		wait_cycles(4);
		write_reg("edge clear all", REG_GPIO_EDGE, 32'h0000FFFF, 4'hF, 0, got_resp);
		read_reg("edge empty", REG_GPIO_EDGE, 0, got_data, got_resp);
		check_equal("edge empty", 32'd0, got_data);
		gpio_pins = pat_b;
		wait_cycles(4);
		read_reg("edge rise", REG_GPIO_EDGE, 0, got_data, got_resp);
		check_equal("edge rise", {16'h0, pat_b & ~pat_a}, got_data);
		write_reg("edge w1c", REG_GPIO_EDGE, {16'h0, clr}, 4'hF, 0, got_resp);
		read_reg("edge w1c", REG_GPIO_EDGE, 0, got_data, got_resp);
		check_equal("edge w1c", {16'h0, pat_b & ~pat_a & ~clr}, got_data);

		// PWM with one clamped channel, period written last
		duty_set = '{5, -8, 0, 30};
		for (int c = 0; c < 4; c++)
			write_reg("duty set", REG_PWM_DUTY0 + 8'(4 * c), {16'h0, 16'(duty_set[c])}, 4'hF,
				0, got_resp);
		write_reg("period set", REG_PWM_PERIOD, 32'd20, 4'hF, 0, got_resp);
		// pin 0 rising marks a fresh period with the new shadows
		t    = 0;
		prev = hbr_pins[0];
		@(negedge clock_50mhz);
		while (!(!prev && hbr_pins[0]) && t < PWM_TIMEOUT)
		begin
			prev = hbr_pins[0];
			@(negedge clock_50mhz);
			t++;
		end
		if (t >= PWM_TIMEOUT)
			report_timeout("PWM period wrap");
		highs = '{default: 0};
		for (int s = 0; s < 20; s++)
		begin
			if (s > 0)
				@(negedge clock_50mhz);
			for (int p = 0; p < 8; p++)
				highs[p] += hbr_pins[p];
		end
		for (int p = 0; p < 8; p++)
			check_equal($sformatf("pwm pin %0d", p), expected_highs(p, duty_set[p / 2], 20),
				highs[p]);

		// back-pressure on both response channels
		write_reg("stall write", REG_PWM_DUTY2, 32'h00000003, 4'hF, 6, got_resp);
		check_equal("stall write bresp", RESP_OKAY, got_resp);
		read_reg("stall read", REG_PWM_PERIOD, 6, got_data, got_resp);
		check_equal("stall read rresp", RESP_OKAY, got_resp);
		check_equal("stall read rdata", 32'd20, got_data);
		read_reg("stall hole", 8'h30, 4, got_data, got_resp);
		check_equal("stall hole rresp", RESP_SLVERR, got_resp);
		check_equal("stall hole rdata", 32'd0, got_data);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* src.f */
io_pkg.sv
reset_sequencer.sv
axil_reg_slave.sv
gpio_port.sv
hbridge_pwm.sv
board_io_top.sv
tb_clock_gen.sv
board_io_props.sv
board_io_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the board I/O testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module board_io_tb -f src.f \
	-o board_io_sim \
	&& ./obj_dir/board_io_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "FAIL: build or simulation error"; exit 1; }
grep -q "Checks failed" sim.log && { cat sim.log; echo "FAIL"; exit 1; }
grep -q "All checks passed" sim.log || { cat sim.log; echo "FAIL: no result line"; exit 1; }
cat sim.log
echo "PASS"
